// ==== verilog/ipf_pkg.sv ====
package ipf_pkg;

    localparam int PIXEL_W   = 8;
    localparam int COORD_W   = 7;
    localparam int LCU_IDX_W = 3;
    localparam int ADDR_W    = 14;
    localparam int PIC_W     = 128;
    localparam int LAST_ADDR = 16383;
    localparam int OFFSET_W  = 4;

    typedef enum logic [1:0] {
        MODE_OFF,
        MODE_BAND,
        MODE_EDGE
    } ipf_mode_t;

    // Highest in-LCU coordinate for the size code
    function automatic logic [COORD_W-1:0] lcu_last_coord(input logic [1:0] code);
        logic [COORD_W-1:0] last;
        case (code)
            2'd0:    last = COORD_W'(15);
            2'd1:    last = COORD_W'(31);
            default: last = COORD_W'(63);
        endcase
        return last;
    endfunction

    // Fields 0 and 1 add, fields 2 and 3 are two's complement
    function automatic logic [PIXEL_W-1:0] apply_offset(
        input logic [PIXEL_W-1:0]    sample,
        input logic [4*OFFSET_W-1:0] offsets,
        input logic [1:0]            idx
    );
        logic [OFFSET_W-1:0]       field;
        logic [PIXEL_W+1:0]        field_ext;
        logic signed [PIXEL_W+1:0] sum;
        field = offsets[(3 - idx) * OFFSET_W +: OFFSET_W];
        if (idx[1]) begin
            field_ext = {{(PIXEL_W + 2 - OFFSET_W){field[OFFSET_W-1]}}, field};
        end else begin
            field_ext = {{(PIXEL_W + 2 - OFFSET_W){1'b0}}, field};
        end
        sum = $signed({2'b00, sample}) + $signed(field_ext);
        if (sum < 0) begin
            return '0;
        end else if (sum > (1 << PIXEL_W) - 1) begin
            return '1; // Saturate high
        end
        return sum[PIXEL_W-1:0];
    endfunction

endpackage

// ==== verilog/ipf_lcu_scan.sv ====
`timescale 1ns/1ps

module ipf_lcu_scan (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_en,
    input  logic [ipf_pkg::PIXEL_W-1:0]   din,
    input  logic [1:0]                    ipf_type,
    input  logic [4:0]                    ipf_band_pos,
    input  logic [15:0]                   ipf_offset,
    input  logic [ipf_pkg::LCU_IDX_W-1:0] lcu_x,
    input  logic [ipf_pkg::LCU_IDX_W-1:0] lcu_y,
    input  logic [1:0]                    lcu_size,
    output logic                          pix_valid,
    output logic [ipf_pkg::PIXEL_W-1:0]   pix,
    output logic [ipf_pkg::COORD_W-1:0]   pix_x,
    output logic [ipf_pkg::COORD_W-1:0]   pix_y,
    output logic                          row_last,
    output logic                          lcu_last,
    output ipf_pkg::ipf_mode_t            mode,
    output logic [4:0]                    band_pos,
    output logic [15:0]                   offsets,
    output logic [ipf_pkg::LCU_IDX_W-1:0] base_x,
    output logic [ipf_pkg::LCU_IDX_W-1:0] base_y,
    output logic [1:0]                    size_code
);

    logic [ipf_pkg::COORD_W-1:0] cnt_x;
    logic [ipf_pkg::COORD_W-1:0] cnt_y;
    logic [ipf_pkg::COORD_W-1:0] last_coord;
    logic                        first_pix;
    logic                        at_row_end;

    assign first_pix  = (cnt_x == '0) && (cnt_y == '0);
    // Size input only counts on the first pixel
    assign last_coord = first_pix ? ipf_pkg::lcu_last_coord(lcu_size)
                                  : ipf_pkg::lcu_last_coord(size_code);
    assign at_row_end = (cnt_x == last_coord);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt_x     <= '0;
            cnt_y     <= '0;
            pix_valid <= 1'b0;
            pix_x     <= '0;
            pix_y     <= '0;
            row_last  <= 1'b0;
            lcu_last  <= 1'b0;
            mode      <= ipf_pkg::MODE_OFF;
            band_pos  <= '0;
            offsets   <= '0;
            base_x    <= '0;
            base_y    <= '0;
            size_code <= '0;
        end else begin
            pix_valid <= in_en;
            if (in_en) begin
                pix_x    <= cnt_x;
                pix_y    <= cnt_y;
                row_last <= at_row_end;
                lcu_last <= at_row_end && (cnt_y == last_coord);
                if (at_row_end) begin
                    cnt_x <= '0;
                    cnt_y <= (cnt_y == last_coord) ? '0 : cnt_y + 1'b1; // Wrap for next LCU
                end else begin
                    cnt_x <= cnt_x + 1'b1;
                end
                if (first_pix) begin
                    case (ipf_type)
                        2'd0:    mode <= ipf_pkg::MODE_OFF;
                        2'd1:    mode <= ipf_pkg::MODE_BAND;
                        default: mode <= ipf_pkg::MODE_EDGE;
                    endcase
                    band_pos  <= ipf_band_pos;
                    offsets   <= ipf_offset;
                    base_x    <= lcu_x;
                    base_y    <= lcu_y;
                    size_code <= lcu_size;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_en) begin
            pix <= din;
        end
    end

endmodule

// ==== verilog/ipf_band_offset.sv ====
`timescale 1ns/1ps

module ipf_band_offset (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pix_valid,
    input  logic [ipf_pkg::PIXEL_W-1:0] pix,
    input  ipf_pkg::ipf_mode_t          mode,
    input  logic [4:0]                  band_pos,
    input  logic [15:0]                 offsets,
    input  logic [ipf_pkg::COORD_W-1:0] pix_x,
    input  logic [ipf_pkg::COORD_W-1:0] pix_y,
    input  logic                        lcu_last,
    output logic                        band_valid,
    output logic [ipf_pkg::PIXEL_W-1:0] band_pix,
    output logic [ipf_pkg::COORD_W-1:0] band_x,
    output logic [ipf_pkg::COORD_W-1:0] band_y,
    output logic                        band_last
);

    logic [4:0] band;
    logic       excluded;
    logic       active;

    assign band     = pix[ipf_pkg::PIXEL_W-1 -: 5]; // 32 bands of 8
    // Neighbouring bands wrap modulo 32
    assign excluded = (band == band_pos) || (band == band_pos + 5'd1) ||
                      (band == band_pos - 5'd1);
    assign active   = pix_valid && (mode != ipf_pkg::MODE_EDGE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            band_valid <= 1'b0;
            band_last  <= 1'b0;
        end else begin
            band_valid <= active;
            band_last  <= active && lcu_last;
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            band_x <= pix_x;
            band_y <= pix_y;
            if (mode == ipf_pkg::MODE_OFF || excluded) begin
                band_pix <= pix;
            end else begin
                band_pix <= ipf_pkg::apply_offset(pix, offsets, band[1:0]);
            end
        end
    end

endmodule

// ==== verilog/ipf_edge_offset.sv ====
`timescale 1ns/1ps

module ipf_edge_offset (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pix_valid,
    input  logic [ipf_pkg::PIXEL_W-1:0] pix,
    input  ipf_pkg::ipf_mode_t          mode,
    input  logic [15:0]                 offsets,
    input  logic [ipf_pkg::COORD_W-1:0] pix_x,
    input  logic [ipf_pkg::COORD_W-1:0] pix_y,
    input  logic                        row_last,
    input  logic                        lcu_last,
    output logic                        edge_valid,
    output logic [ipf_pkg::PIXEL_W-1:0] edge_pix,
    output logic [ipf_pkg::COORD_W-1:0] edge_x,
    output logic [ipf_pkg::COORD_W-1:0] edge_y,
    output logic                        edge_last
);

    logic [ipf_pkg::PIXEL_W-1:0] win_l;
    logic [ipf_pkg::PIXEL_W-1:0] win_c;
    logic [ipf_pkg::COORD_W-1:0] c_x;
    logic [ipf_pkg::COORD_W-1:0] c_y;
    logic                        c_last;
    logic                        flush_pend;
    logic                        active;
    logic                        emit_centre;
    logic [ipf_pkg::PIXEL_W:0]   twice_c;
    logic [ipf_pkg::PIXEL_W:0]   sum_lr;
    logic [1:0]                  edge_idx;
    logic                        apply_en;
    logic [ipf_pkg::PIXEL_W-1:0] centre_out;

    assign active      = pix_valid && (mode == ipf_pkg::MODE_EDGE);
    assign emit_centre = active && (pix_x != '0); // Row start only fills the window
    assign twice_c     = {win_c, 1'b0};
    assign sum_lr      = {1'b0, win_l} + {1'b0, pix};

    // Incoming pixel is the right neighbour
    always_comb begin
        edge_idx = 2'd0;
        apply_en = 1'b1;
        if (win_c < win_l && win_c < pix) begin
            edge_idx = 2'd0;
        end else if (win_c > win_l && win_c > pix) begin
            edge_idx = 2'd3;
        end else if (twice_c < sum_lr) begin
            edge_idx = 2'd1;
        end else if (twice_c > sum_lr) begin
            edge_idx = 2'd2;
        end else begin
            apply_en = 1'b0;
        end
    end

    assign centre_out = (apply_en && c_x != '0) ? ipf_pkg::apply_offset(win_c, offsets, edge_idx)
                                                : win_c;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flush_pend <= 1'b0;
            edge_valid <= 1'b0;
            edge_last  <= 1'b0;
        end else begin
            edge_valid <= flush_pend || emit_centre;
            edge_last  <= flush_pend && c_last;
            if (active) begin
                flush_pend <= row_last;
            end else begin
                flush_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flush_pend) begin
            edge_pix <= win_c; // Row-last pixel leaves unchanged
            edge_x   <= c_x;
            edge_y   <= c_y;
        end else if (emit_centre) begin
            edge_pix <= centre_out;
            edge_x   <= c_x;
            edge_y   <= c_y;
        end
        if (active) begin
            win_l  <= win_c;
            win_c  <= pix;
            c_x    <= pix_x;
            c_y    <= pix_y;
            c_last <= lcu_last;
        end
    end

endmodule

// ==== verilog/ipf_out_stage.sv ====
`timescale 1ns/1ps

module ipf_out_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  ipf_pkg::ipf_mode_t            mode,
    input  logic [ipf_pkg::LCU_IDX_W-1:0] base_x,
    input  logic [ipf_pkg::LCU_IDX_W-1:0] base_y,
    input  logic [1:0]                    size_code,
    input  logic                          pix_valid,
    input  logic                          lcu_last,
    input  logic                          band_valid,
    input  logic [ipf_pkg::PIXEL_W-1:0]   band_pix,
    input  logic [ipf_pkg::COORD_W-1:0]   band_x,
    input  logic [ipf_pkg::COORD_W-1:0]   band_y,
    input  logic                          band_last,
    input  logic                          edge_valid,
    input  logic [ipf_pkg::PIXEL_W-1:0]   edge_pix,
    input  logic [ipf_pkg::COORD_W-1:0]   edge_x,
    input  logic [ipf_pkg::COORD_W-1:0]   edge_y,
    input  logic                          edge_last,
    output logic                          out_en,
    output logic [ipf_pkg::PIXEL_W-1:0]   dout,
    output logic [ipf_pkg::ADDR_W-1:0]    dout_addr,
    output logic                          busy,
    output logic                          finish
);

    logic                          sel_valid;
    logic [ipf_pkg::PIXEL_W-1:0]   sel_pix;
    logic [ipf_pkg::COORD_W-1:0]   sel_x;
    logic [ipf_pkg::COORD_W-1:0]   sel_y;
    logic                          sel_last;
    logic [ipf_pkg::ADDR_W-1:0]    side;
    logic [ipf_pkg::ADDR_W-1:0]    row;
    logic [ipf_pkg::ADDR_W-1:0]    col;
    logic                          out_last;
    logic                          busy_r;

    always_comb begin
        if (mode == ipf_pkg::MODE_EDGE) begin
            sel_valid = edge_valid;
            sel_pix   = edge_pix;
            sel_x     = edge_x;
            sel_y     = edge_y;
            sel_last  = edge_last;
        end else begin
            sel_valid = band_valid;
            sel_pix   = band_pix;
            sel_x     = band_x;
            sel_y     = band_y;
            sel_last  = band_last;
        end
    end

    // Picture position of the selected pixel
    assign side = ipf_pkg::ADDR_W'(ipf_pkg::lcu_last_coord(size_code)) + 1'b1;
    assign row  = ipf_pkg::ADDR_W'(base_y) * side + ipf_pkg::ADDR_W'(sel_y);
    assign col  = ipf_pkg::ADDR_W'(base_x) * side + ipf_pkg::ADDR_W'(sel_x);

    // High from the last scanned pixel until its output has gone
    assign busy = busy_r || (pix_valid && lcu_last);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_en    <= 1'b0;
            out_last  <= 1'b0;
            dout      <= '0;
            dout_addr <= '0;
            busy_r    <= 1'b0;
            finish    <= 1'b0;
        end else begin
            out_en   <= sel_valid;
            out_last <= sel_valid && sel_last;
            if (sel_valid) begin
                dout      <= sel_pix;
                dout_addr <= row * ipf_pkg::ADDR_W'(ipf_pkg::PIC_W) + col;
            end
            if (pix_valid && lcu_last) begin
                busy_r <= 1'b1;
            end else if (out_en && out_last) begin
                busy_r <= 1'b0;
            end
            finish <= out_en && (dout_addr == ipf_pkg::ADDR_W'(ipf_pkg::LAST_ADDR));
        end
    end

endmodule

// ==== verilog/ipf.sv ====
`timescale 1ns/1ps

module ipf (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_en,
    input  logic [ipf_pkg::PIXEL_W-1:0]   din,
    input  logic [1:0]                    ipf_type,
    input  logic [4:0]                    ipf_band_pos,
    input  logic [15:0]                   ipf_offset,
    input  logic [ipf_pkg::LCU_IDX_W-1:0] lcu_x,
    input  logic [ipf_pkg::LCU_IDX_W-1:0] lcu_y,
    input  logic [1:0]                    lcu_size,
    output logic                          busy,
    output logic                          out_en,
    output logic [ipf_pkg::PIXEL_W-1:0]   dout,
    output logic [ipf_pkg::ADDR_W-1:0]    dout_addr,
    output logic                          finish
);

    logic                          pix_valid;
    logic [ipf_pkg::PIXEL_W-1:0]   pix;
    logic [ipf_pkg::COORD_W-1:0]   pix_x;
    logic [ipf_pkg::COORD_W-1:0]   pix_y;
    logic                          row_last;
    logic                          lcu_last;
    ipf_pkg::ipf_mode_t            mode;
    logic [4:0]                    band_pos;
    logic [15:0]                   offsets;
    logic [ipf_pkg::LCU_IDX_W-1:0] base_x;
    logic [ipf_pkg::LCU_IDX_W-1:0] base_y;
    logic [1:0]                    size_code;

    logic                          band_valid;
    logic [ipf_pkg::PIXEL_W-1:0]   band_pix;
    logic [ipf_pkg::COORD_W-1:0]   band_x;
    logic [ipf_pkg::COORD_W-1:0]   band_y;
    logic                          band_last;

    logic                          edge_valid;
    logic [ipf_pkg::PIXEL_W-1:0]   edge_pix;
    logic [ipf_pkg::COORD_W-1:0]   edge_x;
    logic [ipf_pkg::COORD_W-1:0]   edge_y;
    logic                          edge_last;

    ipf_lcu_scan i_scan (
        .clk, .reset, .in_en, .din, .ipf_type, .ipf_band_pos, .ipf_offset,
        .lcu_x, .lcu_y, .lcu_size, .pix_valid, .pix, .pix_x, .pix_y,
        .row_last, .lcu_last, .mode, .band_pos, .offsets, .base_x, .base_y,
        .size_code
    );

    ipf_band_offset i_band (
        .clk, .reset, .pix_valid, .pix, .mode, .band_pos, .offsets, .pix_x,
        .pix_y, .lcu_last, .band_valid, .band_pix, .band_x, .band_y, .band_last
    );

    ipf_edge_offset i_edge (
        .clk, .reset, .pix_valid, .pix, .mode, .offsets, .pix_x, .pix_y,
        .row_last, .lcu_last, .edge_valid, .edge_pix, .edge_x, .edge_y, .edge_last
    );

    ipf_out_stage i_out (
        .clk, .reset, .mode, .base_x, .base_y, .size_code, .pix_valid, .lcu_last,
        .band_valid, .band_pix, .band_x, .band_y, .band_last,
        .edge_valid, .edge_pix, .edge_x, .edge_y, .edge_last,
        .out_en, .dout, .dout_addr, .busy, .finish
    );

endmodule

// ==== sim/ipf_model.svh ====
`ifndef IPF_MODEL_SVH
`define IPF_MODEL_SVH

function automatic int side_of(input int size_code);
    if (size_code == 0) begin
        return 16;
    end else if (size_code == 1) begin
        return 32;
    end
    return 64;
endfunction

// Field 0 sits in the top nibble, fields 2 and 3 are signed
function automatic int add_field(input int sample, input int offsets, input int idx);
    int field;
    int sum;
    field = (offsets >> ((3 - idx) * 4)) & 15;
    if (idx >= 2 && field >= 8) begin
        field = field - 16;
    end
    sum = sample + field;
    if (sum < 0) begin
        sum = 0;
    end else if (sum > 255) begin
        sum = 255;
    end
    return sum;
endfunction

function automatic int band_model(input int lcu_type, input int sample, input int band_pos,
                                  input int offsets);
    int band;
    band = sample / 8;
    if (lcu_type == 0) begin
        return sample;
    end
    if (band == band_pos || band == (band_pos + 1) % 32 || band == (band_pos + 31) % 32) begin
        return sample; // Bands next to band_pos stay untouched
    end
    return add_field(sample, offsets, band % 4);
endfunction

function automatic int edge_model(input int l, input int c, input int r, input int offsets);
    if (c < l && c < r) begin
        return add_field(c, offsets, 0);
    end else if (c > l && c > r) begin
        return add_field(c, offsets, 3);
    end else if (2 * c < l + r) begin
        return add_field(c, offsets, 1);
    end else if (2 * c > l + r) begin
        return add_field(c, offsets, 2);
    end
    return c;
endfunction

function automatic int addr_model(input int size_code, input int bx, input int by,
                                  input int x, input int y);
    int side;
    side = side_of(size_code);
    return (by * side + y) * 128 + bx * side + x;
endfunction

`endif

// ==== sim/ipf_tb.sv ====
`timescale 1ns/1ps

module ipf_tb;

    localparam int NUM_LCU       = 15;
    localparam int LAST_PIX_ADDR = 16383;

    `include "ipf_model.svh"

    logic        clk;
    logic        reset;
    logic        in_en;
    logic [7:0]  din;
    logic [1:0]  ipf_type;
    logic [4:0]  ipf_band_pos;
    logic [15:0] ipf_offset;
    logic [2:0]  lcu_x;
    logic [2:0]  lcu_y;
    logic [1:0]  lcu_size;
    logic        busy;
    logic        out_en;
    logic [7:0]  dout;
    logic [13:0] dout_addr;
    logic        finish;
    logic        drv_last; // Final pixel of the LCU on in_en

    int exp_dout[$];
    int exp_addr[$];
    bit exp_last[$];
    bit exp_timed[$];
    int accept_cyc[$];
    int pix_mem[4096];
    int lcu_sz[NUM_LCU];
    int cyc;
    int errors;
    int fin_count;
    int tests_passed;
    int tests_failed;
    int test_start_err;
    int lcu_idx;
    int total_pix;
    int addr_exp;
    int wd_cycles = 0;
    bit busy_exp = 1'b0;
    bit fin_exp = 1'b0;
    int cur_type;
    int cur_size;
    int cur_band_pos;
    int cur_offset;
    int cur_bx;
    int cur_by;

    ipf i_ipf (
        .clk, .reset, .in_en, .din, .ipf_type, .ipf_band_pos, .ipf_offset,
        .lcu_x, .lcu_y, .lcu_size, .busy, .out_en, .dout, .dout_addr, .finish
    );

    always #10 clk = ~clk;

    task automatic check_val(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic close_test(input string name);
        if (errors == test_start_err) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("Test %s done with %0d errors", name, errors - test_start_err);
        test_start_err = errors;
    endtask

    task automatic scramble_settings();
        ipf_type     <= 2'($urandom);
        ipf_band_pos <= 5'($urandom);
        ipf_offset   <= 16'($urandom);
        lcu_x        <= 3'($urandom);
        lcu_y        <= 3'($urandom);
        lcu_size     <= 2'($urandom);
    endtask

    task automatic make_lcu(input int lcu_type, input int size_code, input bit corner,
                            input bit extremes);
        int side;
        int max_idx;
        int i;
        side         = side_of(size_code);
        max_idx      = 128 / side - 1;
        cur_type     = lcu_type;
        cur_size     = size_code;
        cur_band_pos = $urandom_range(0, 31);
        cur_offset   = $urandom_range(0, 65535);
        cur_bx       = $urandom_range(0, max_idx);
        cur_by       = $urandom_range(0, max_idx);
        if (corner) begin
            cur_bx = max_idx;
            cur_by = max_idx;
        end else if (cur_bx == max_idx && cur_by == max_idx) begin
            cur_bx = 0; // Bottom-right corner only at the end
        end
        for (i = 0; i < side * side; i++) begin
            pix_mem[i] = $urandom_range(0, 255);
            if (extremes && $urandom_range(0, 3) == 0) begin
                pix_mem[i] = ($urandom_range(0, 1) == 1) ? $urandom_range(248, 255)
                                                         : $urandom_range(0, 7);
            end
        end
    endtask

    task automatic send_lcu(input bit gaps);
        int side;
        int x;
        int y;
        int i;
        int c;
        int res;
        int gap;
        side = side_of(cur_size);
        for (y = 0; y < side; y++) begin
            for (x = 0; x < side; x++) begin
                c = pix_mem[y * side + x];
                if (cur_type < 2) begin
                    res = band_model(cur_type, c, cur_band_pos, cur_offset);
                end else if (x == 0 || x == side - 1) begin
                    res = c;
                end else begin
                    res = edge_model(pix_mem[y * side + x - 1], c, pix_mem[y * side + x + 1],
                                     cur_offset);
                end
                exp_dout.push_back(res);
                exp_addr.push_back(addr_model(cur_size, cur_bx, cur_by, x, y));
                exp_last.push_back(x == side - 1 && y == side - 1);
                exp_timed.push_back(cur_type < 2);
            end
        end
        for (i = 0; i < side * side; i++) begin
            gap = gaps ? $urandom_range(0, 3) : 0;
            repeat (gap) begin
                in_en    <= 1'b0;
                drv_last <= 1'b0;
                din      <= 8'($urandom);
                scramble_settings();
                @(posedge clk);
            end
            in_en    <= 1'b1;
            din      <= 8'(pix_mem[i]);
            drv_last <= (i == side * side - 1);
            if (i == 0) begin
                ipf_type     <= 2'(cur_type);
                ipf_band_pos <= 5'(cur_band_pos);
                ipf_offset   <= 16'(cur_offset);
                lcu_x        <= 3'(cur_bx);
                lcu_y        <= 3'(cur_by);
                lcu_size     <= 2'(cur_size);
            end else begin
                scramble_settings();
            end
            if (cur_type < 2) begin
                accept_cyc.push_back(cyc + 1);
            end
            @(posedge clk);
        end
        in_en    <= 1'b0;
        drv_last <= 1'b0;
        do begin
            @(posedge clk);
        end while (exp_dout.size() != 0 || busy);
    endtask

    // Output monitor and status tracking
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (!reset) begin
            check_val("busy", int'(busy), int'(busy_exp));
            check_val("finish", int'(finish), int'(fin_exp));
            if (finish) begin
                fin_count++;
            end
            fin_exp = 1'b0;
            if (in_en && drv_last) begin
                busy_exp = 1'b1;
            end
            if (out_en) begin
                if (exp_dout.size() == 0) begin
                    $display("Output at address %0d arrived with no pixel pending", dout_addr);
                    errors++;
                end else begin
                    addr_exp = exp_addr.pop_front();
                    check_val("dout", int'(dout), exp_dout.pop_front());
                    check_val("dout_addr", int'(dout_addr), addr_exp);
                    fin_exp = (addr_exp == LAST_PIX_ADDR);
                    if (exp_timed.pop_front()) begin
                        check_val("out_en latency", cyc - accept_cyc.pop_front(), 3);
                    end
                    if (exp_last.pop_front()) begin
                        busy_exp = 1'b0;
                    end
                end
            end
        end
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout: the run went past %0d cycles without completing", wd_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hc963));
        clk          = 1'b0;
        reset        = 1'b1;
        in_en        = 1'b0;
        din          = '0;
        ipf_type     = '0;
        ipf_band_pos = '0;
        ipf_offset   = '0;
        lcu_x        = '0;
        lcu_y        = '0;
        lcu_size     = '0;
        drv_last     = 1'b0;
        cyc          = 0;
        errors       = 0;
        fin_count    = 0;
        for (lcu_idx = 0; lcu_idx < NUM_LCU; lcu_idx++) begin
            lcu_sz[lcu_idx] = $urandom_range(0, 3);
        end
        lcu_sz[6]  = 0; // Edge LCUs cover every size
        lcu_sz[7]  = 1;
        lcu_sz[8]  = 2;
        lcu_sz[11] = lcu_sz[10];
        lcu_sz[13] = lcu_sz[12];
        total_pix = 0;
        for (lcu_idx = 0; lcu_idx < NUM_LCU; lcu_idx++) begin
            total_pix += side_of(lcu_sz[lcu_idx]) * side_of(lcu_sz[lcu_idx]);
        end
        wd_cycles = total_pix * 4 + 200;

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_val("out_en", int'(out_en), 0);
        check_val("busy", int'(busy), 0);
        check_val("finish", int'(finish), 0);
        check_val("dout", int'(dout), 0);
        close_test("reset state");

        for (lcu_idx = 0; lcu_idx < 3; lcu_idx++) begin
            make_lcu(0, lcu_sz[lcu_idx], 1'b0, 1'b0);
            send_lcu(1'b0);
        end
        close_test("off mode");

        for (lcu_idx = 3; lcu_idx < 6; lcu_idx++) begin
            make_lcu(1, lcu_sz[lcu_idx], 1'b0, 1'b1);
            send_lcu(1'b0);
        end
        close_test("band offset");

        for (lcu_idx = 6; lcu_idx < 10; lcu_idx++) begin
            make_lcu(2 + $urandom_range(0, 1), lcu_sz[lcu_idx], 1'b0, 1'b1);
            send_lcu(1'b0);
        end
        close_test("edge offset");

        // Same LCU twice, without and with gaps
        for (lcu_idx = 10; lcu_idx < 14; lcu_idx += 2) begin
            make_lcu($urandom_range(0, 3), lcu_sz[lcu_idx], 1'b0, 1'b0);
            send_lcu(1'b0);
            send_lcu(1'b1);
        end
        close_test("in_en gaps");

        make_lcu($urandom_range(0, 3), lcu_sz[14], 1'b1, 1'b0);
        send_lcu(1'b1);
        @(posedge clk);
        if (fin_count != 1) begin
            $display("The finish pulse came %0d times instead of once", fin_count);
            errors++;
        end
        close_test("busy and finish");

        $display("Summary: %0d tests clean, %0d tests with errors", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+sim
verilog/ipf_pkg.sv
verilog/ipf_lcu_scan.sv
verilog/ipf_band_offset.sv
verilog/ipf_edge_offset.sv
verilog/ipf_out_stage.sv
verilog/ipf.sv
sim/ipf_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module ipf_tb -o ipf_sim

./obj_dir/ipf_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
